// ==== ntm_vector_tanh_function.f ====
+incdir+include
hw/ntm_arith_pkg.sv
hw/ntm_control_pkg.sv
hw/ntm_modular_multiplier.sv
hw/ntm_modular_power.sv
hw/ntm_scalar_tanh_function.sv
hw/ntm_vector_tanh_function.sv
verif/ntm_vector_tanh_function_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vector tanh testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f ntm_vector_tanh_function.f \
  --top-module ntm_vector_tanh_function_tb \
  -o ntm_vector_tanh_function_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ntm_vector_tanh_function_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Test completed successfully$" sim.log; then
  exit 0
fi
exit 1

// ==== include/ntm_tanh_model.svh ====
`ifndef NTM_TANH_MODEL_SVH
`define NTM_TANH_MODEL_SVH

// a*b mod p
function automatic longint unsigned product_mod(input longint unsigned a,
                                                input longint unsigned b,
                                                input longint unsigned p);
  return (a * b) % p;
endfunction

// b^e mod p where exponent 0 gives 1 mod p
function automatic longint unsigned power_mod(input longint unsigned b,
                                              input longint unsigned e,
                                              input longint unsigned p);
  longint unsigned result;
  longint unsigned square;
  longint unsigned rest;
  result = 1 % p;
  square = b % p;
  rest   = e;
  while (rest != 0) begin
    if (rest[0]) begin
      result = product_mod(result, square, p);
    end
    square = product_mod(square, square, p);
    rest   = rest >> 1;
  end
  return result;
endfunction

// (9^x - 1) * (9^x + 1)^(p-2) mod p
function automatic longint unsigned expected_tanh(input longint unsigned x,
                                                  input longint unsigned p);
  longint unsigned e;
  longint unsigned num;
  longint unsigned den;
  e   = power_mod(9, x, p);
  num = (e + p - 1) % p;
  den = (e + 1) % p;
  return product_mod(num, power_mod(den, p - 2, p), p);
endfunction

// Smallest x with 9^x = p-1 mod p and -1 when none exists
function automatic int find_minus_one_exponent(input longint unsigned p);
  for (longint unsigned x = 0; x < p; x++) begin
    if (power_mod(9, x, p) == p - 1) begin
      return int'(x);
    end
  end
  return -1;
endfunction

`endif

// ==== verif/ntm_vector_tanh_function_tb.sv ====
module ntm_vector_tanh_function_tb
  import ntm_arith_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  `include "ntm_tanh_model.svh"

  // Longest element at p = 65521 is well under this
  localparam int TIMEOUT_CYCLES = 5000;

  // DUT side
  logic CLK;
  logic RST;
  logic start;
  logic ready;
  logic data_in_enable;
  logic data_out_enable;
  ntm_word_t modulo_in;
  ntm_index_t size_in;
  ntm_word_t data_in;
  ntm_word_t data_out;

  // Scoreboard
  ntm_word_t expected_q[$];
  ntm_word_t data_q[$];
  int expected_count;
  int out_count;
  int run_last_index;
  logic started;
  int error_count;
  int timeout_count;
  integer seed;

  always #4 CLK = ~CLK;

  ntm_vector_tanh_function ntm_vector_tanh_function_inst (
    .CLK            (CLK),
    .RST            (RST),
    .START          (start),
    .READY          (ready),
    .DATA_IN_ENABLE (data_in_enable),
    .DATA_OUT_ENABLE(data_out_enable),
    .MODULO_IN      (modulo_in),
    .SIZE_IN        (size_in),
    .DATA_IN        (data_in),
    .DATA_OUT       (data_out)
  );

  // Count output strobes and note the first START on the DUT edge
  always @(posedge CLK) begin
    if (RST) begin
      out_count <= 0;
      started   <= 1'b0;
    end else begin
      if (data_out_enable) begin
        out_count <= out_count + 1;
      end
      if (start) begin
        started <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // Checks on the falling edge
  //////////////////////////////

  // Outputs quiet until the first run
  quiet_before_start_a : assert property (@(negedge CLK) disable iff (RST)
    !started |-> !ready && !data_out_enable && data_out == '0)
  else begin
    error_count++;
    $display("Error: before START ready = %h, data_out_enable = %h, data_out = %h, expected 0",
             ready, data_out_enable, data_out);
  end

  output_value_a : assert property (@(negedge CLK) disable iff (RST)
    data_out_enable && out_count < expected_count |-> data_out == expected_q[out_count])
  else begin
    error_count++;
    $display("Error: data_out = %h, expected %h", data_out, expected_q[out_count]);
  end

  // No strobe beyond the elements sent
  output_expected_a : assert property (@(negedge CLK) disable iff (RST)
    data_out_enable |-> out_count < expected_count)
  else begin
    error_count++;
    $display("Output strobe arrived with no element pending");
  end

  // READY on the last strobe of a run and on no other
  ready_on_last_a : assert property (@(negedge CLK) disable iff (RST)
    data_out_enable |-> ready == (out_count == run_last_index))
  else begin
    error_count++;
    $display("Error: ready = %h, expected %h", ready, out_count == run_last_index);
  end

  ready_with_strobe_a : assert property (@(negedge CLK) disable iff (RST)
    ready |-> data_out_enable)
  else begin
    error_count++;
    $display("READY pulsed without an output strobe");
  end

  //////////////////////////////
  // Tasks
  //////////////////////////////

  task automatic finish_with_summary();
    $display("Summary: %0d errors, %0d timeouts, %0d outputs",
             error_count, timeout_count, out_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // Returns on the falling edge that shows the strobe
  task automatic wait_for_output();
    int cycles;
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
    end while (!data_out_enable && cycles < TIMEOUT_CYCLES);
    if (!data_out_enable) begin
      timeout_count++;
      $display("Timeout, no output strobe within %0d cycles", TIMEOUT_CYCLES);
      finish_with_summary();
    end
  endtask

  task automatic fill_random(input ntm_word_t modulo, input int count);
    data_q.delete();
    for (int i = 0; i < count; i++) begin
      data_q.push_back(ntm_word_t'($unsigned($random(seed)) % modulo));
    end
  endtask

  // Drives one vector from data_q with optional noise while the scalar unit is busy
  task automatic run_vector(input ntm_word_t modulo, input ntm_index_t size,
                            input logic disturb);
    int elements;
    elements = (size == '0) ? 1 : int'(size);
    @(negedge CLK);
    start          = 1'b1;
    modulo_in      = modulo;
    size_in        = size;
    run_last_index = expected_count + elements - 1;
    @(negedge CLK);
    start     = 1'b0;
    // Sampled at START only, so scramble them
    modulo_in = ~modulo;
    size_in   = ~size;
    for (int i = 0; i < elements; i++) begin
      data_in        = data_q[i];
      data_in_enable = 1'b1;
      expected_q.push_back(ntm_word_t'(expected_tanh(data_q[i], modulo)));
      expected_count++;
      @(negedge CLK);
      data_in_enable = 1'b0;
      data_in        = ~data_q[i];
      if (disturb) begin
        // DUT is in ENDER here
        start          = 1'b1;
        data_in_enable = 1'b1;
        @(negedge CLK);
        start          = 1'b0;
        data_in_enable = 1'b0;
      end
      wait_for_output();
      @(negedge CLK);
    end
    assert (out_count == expected_count) else begin
      error_count++;
      $display("Error: output strobe count = %h, expected %h", out_count, expected_count);
    end
  endtask

  // x = 0 and an x with 9^x = -1 mod p both give 0
  task automatic run_special_inputs();
    int candidates[4] = '{7, 11, 13, 17};
    int minus_one_x;
    ntm_word_t p;
    minus_one_x = -1;
    p = ntm_word_t'(17);
    foreach (candidates[i]) begin
      if (minus_one_x < 0) begin
        minus_one_x = find_minus_one_exponent(candidates[i]);
        p = ntm_word_t'(candidates[i]);
      end
    end
    assert (minus_one_x >= 0) else begin
      error_count++;
      $display("No candidate prime has an x with 9^x = -1 mod p");
    end
    data_q.delete();
    data_q.push_back(ntm_word_t'(minus_one_x));
    data_q.push_back('0);
    data_q.push_back(ntm_word_t'($unsigned($random(seed)) % p));
    run_vector(p, ntm_index_t'(3), 1'b0);
  endtask

  //////////////////////////////
  // Sequence
  //////////////////////////////

  initial begin
    CLK            = 1'b0;
    RST            = 1'b1;
    start          = 1'b0;
    data_in_enable = 1'b0;
    modulo_in      = '0;
    size_in        = '0;
    data_in        = '0;
    seed           = 32'hd624;
    expected_count = 0;
    run_last_index = -1;
    error_count    = 0;
    timeout_count  = 0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    // Idle stretch for the reset checks
    repeat (10) @(negedge CLK);

    fill_random(ntm_word_t'(7), 6);
    run_vector(ntm_word_t'(7), ntm_index_t'(6), 1'b0);
    fill_random(ntm_word_t'(251), 5);
    run_vector(ntm_word_t'(251), ntm_index_t'(5), 1'b0);
    fill_random(ntm_word_t'(65521), 4);
    run_vector(ntm_word_t'(65521), ntm_index_t'(4), 1'b0);

    // Single element with x = 0
    data_q.delete();
    data_q.push_back('0);
    run_vector(ntm_word_t'(251), ntm_index_t'(1), 1'b0);

    // Size 0 runs one element
    fill_random(ntm_word_t'(65521), 1);
    run_vector(ntm_word_t'(65521), ntm_index_t'(0), 1'b0);

    run_special_inputs();

    fill_random(ntm_word_t'(251), 3);
    run_vector(ntm_word_t'(251), ntm_index_t'(3), 1'b1);

    repeat (20) @(negedge CLK);
    finish_with_summary();
  end

endmodule

// ==== hw/ntm_vector_tanh_function.sv ====
module ntm_vector_tanh_function
  import ntm_arith_pkg::*;
  import ntm_control_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       START,
  output logic       READY,
  input  logic       DATA_IN_ENABLE,
  output logic       DATA_OUT_ENABLE,
  input  ntm_word_t  MODULO_IN,
  input  ntm_index_t SIZE_IN,
  input  ntm_word_t  DATA_IN,
  output ntm_word_t  DATA_OUT
);

  // FSM
  ntm_vector_state_t state;

  // Run length and position
  ntm_index_t size_r;
  ntm_index_t index_r;

  // Scalar unit
  logic scalar_start;
  logic scalar_ready;
  ntm_word_t scalar_data;
  ntm_modular_operand_t operand_r;

  //////////////////////////////
  // Element walk
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= STARTER;
      size_r          <= '0;
      index_r         <= '0;
      scalar_start    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      scalar_start    <= 1'b0;
      case (state)
        STARTER: begin
          // Empty vector runs as one element
          if (START) begin
            size_r  <= (SIZE_IN == '0) ? ntm_index_t'(1) : SIZE_IN;
            index_r <= '0;
            state   <= INPUT;
          end
        end
        INPUT: begin
          // Every element gets its own scalar run
          if (DATA_IN_ENABLE) begin
            scalar_start <= 1'b1;
            state        <= ENDER;
          end
        end
        ENDER: begin
          if (scalar_ready) begin
            DATA_OUT        <= scalar_data;
            DATA_OUT_ENABLE <= 1'b1;
            if (index_r == size_r - 1'b1) begin
              READY <= 1'b1;
              state <= STARTER;
            end else begin
              index_r <= index_r + 1'b1;
              state   <= INPUT;
            end
          end
        end
        default: state <= STARTER;
      endcase
    end
  end

  // Modulus once per run, data once per element
  always_ff @(posedge CLK) begin
    if (state == STARTER && START) begin
      operand_r.modulo <= MODULO_IN;
    end
    if (state == INPUT && DATA_IN_ENABLE) begin
      operand_r.data <= DATA_IN;
    end
  end

  ntm_scalar_tanh_function scalar_tanh_inst (
    .CLK     (CLK),
    .RST     (RST),
    .START   (scalar_start),
    .operand (operand_r),
    .READY   (scalar_ready),
    .DATA_OUT(scalar_data)
  );

  // Run end only ever rides on an output strobe
  ready_with_output_a : assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_ENABLE);

endmodule

// ==== hw/ntm_scalar_tanh_function.sv ====
module ntm_scalar_tanh_function
  import ntm_arith_pkg::*;
  import ntm_control_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  ntm_modular_operand_t operand,
  output logic                 READY,
  output ntm_word_t            DATA_OUT
);

  // FSM
  ntm_scalar_state_t state;

  // Element and intermediate terms
  ntm_modular_operand_t operand_r;
  ntm_word_t numerator_r;
  ntm_word_t denominator_r;
  ntm_word_t base_reduced;

  // Power unit, used twice
  logic pow_start;
  logic pow_ready;
  ntm_word_t pow_data;
  ntm_power_request_t pow_request;

  // Final product
  logic mul_start;
  logic mul_ready;
  ntm_word_t mul_data;
  ntm_product_request_t mul_request;

  // 9 mod p by repeated subtraction, bounded by the constant itself
  function automatic ntm_word_t reduce_base(input ntm_word_t modulo);
    ntm_word_t residue;
    residue = TANH_BASE_SQUARED;
    for (int i = 0; i < int'(TANH_BASE_SQUARED); i++) begin
      if (residue >= modulo) begin
        residue = residue - modulo;
      end
    end
    return residue;
  endfunction

  assign base_reduced = reduce_base(operand_r.modulo);

  //////////////////////////////
  // Step operands
  //////////////////////////////

  always_comb begin
    pow_request.modulo = operand_r.modulo;
    if (state == INVERSE) begin
      // Fermat inverse, d^(p-2)
      pow_request.base     = denominator_r;
      pow_request.exponent = operand_r.modulo - ntm_word_t'(2);
    end else begin
      pow_request.base     = base_reduced;
      pow_request.exponent = operand_r.data;
    end
    // Power output holds the inverse until its next run
    mul_request.modulo       = operand_r.modulo;
    mul_request.multiplicand = numerator_r;
    mul_request.multiplier   = pow_data;
  end

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= SCALAR_IDLE;
      pow_start <= 1'b0;
      mul_start <= 1'b0;
      READY     <= 1'b0;
      DATA_OUT  <= '0;
    end else begin
      READY     <= 1'b0;
      pow_start <= 1'b0;
      mul_start <= 1'b0;
      case (state)
        SCALAR_IDLE: begin
          if (START) begin
            pow_start <= 1'b1;
            state     <= EXPONENTIAL;
          end
        end
        EXPONENTIAL: begin
          if (pow_ready) begin
            pow_start <= 1'b1;
            state     <= INVERSE;
          end
        end
        INVERSE: begin
          if (pow_ready) begin
            mul_start <= 1'b1;
            state     <= PRODUCT;
          end
        end
        PRODUCT: begin
          if (mul_ready) begin
            READY    <= 1'b1;
            DATA_OUT <= mul_data;
            state    <= SCALAR_IDLE;
          end
        end
        default: state <= SCALAR_IDLE;
      endcase
    end
  end

  // e-1 and e+1 mod p, e+1 wrapping to 0 gives a zero inverse
  always_ff @(posedge CLK) begin
    if (state == SCALAR_IDLE && START) begin
      operand_r <= operand;
    end
    if (state == EXPONENTIAL && pow_ready) begin
      numerator_r <= (pow_data == '0) ? operand_r.modulo - 1'b1 : pow_data - 1'b1;
      denominator_r <= (pow_data == operand_r.modulo - 1'b1) ? '0 : pow_data + 1'b1;
    end
  end

  ntm_modular_power power_inst (
    .CLK     (CLK),
    .RST     (RST),
    .START   (pow_start),
    .request (pow_request),
    .READY   (pow_ready),
    .DATA_OUT(pow_data)
  );

  ntm_modular_multiplier multiplier_inst (
    .CLK     (CLK),
    .RST     (RST),
    .START   (mul_start),
    .request (mul_request),
    .READY   (mul_ready),
    .DATA_OUT(mul_data)
  );

endmodule

// ==== hw/ntm_modular_power.sv ====
module ntm_modular_power
  import ntm_arith_pkg::*;
  import ntm_control_pkg::*;
(
  input  logic               CLK,
  input  logic               RST,
  input  logic               START,
  input  ntm_power_request_t request,
  output logic               READY,
  output ntm_word_t          DATA_OUT
);

  // FSM
  ntm_power_state_t state;
  ntm_bit_index_t bit_index;

  // Latched request and running result
  ntm_word_t modulo_r;
  ntm_word_t base_r;
  ntm_word_t exponent_r;
  ntm_word_t result_r;

  // Shared multiplier
  logic mul_start;
  logic mul_ready;
  ntm_word_t mul_data;
  ntm_product_request_t mul_request;

  // Square uses result twice, multiply folds in the base
  always_comb begin
    mul_request.modulo       = modulo_r;
    mul_request.multiplicand = result_r;
    mul_request.multiplier   = (state == MULTIPLY) ? base_r : result_r;
  end

  //////////////////////////////
  // Square and multiply FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= POWER_IDLE;
      bit_index <= '0;
      mul_start <= 1'b0;
      READY     <= 1'b0;
      DATA_OUT  <= '0;
    end else begin
      READY     <= 1'b0;
      mul_start <= 1'b0;
      case (state)
        POWER_IDLE: begin
          // Scan starts from the top exponent bit
          if (START) begin
            bit_index <= ntm_bit_index_t'(DATA_SIZE - 1);
            mul_start <= 1'b1;
            state     <= SQUARE;
          end
        end
        SQUARE: begin
          if (mul_ready) begin
            if (exponent_r[bit_index]) begin
              mul_start <= 1'b1;
              state     <= MULTIPLY;
            end else if (bit_index == '0) begin
              READY    <= 1'b1;
              DATA_OUT <= mul_data;
              state    <= POWER_IDLE;
            end else begin
              bit_index <= bit_index - 1'b1;
              mul_start <= 1'b1;
            end
          end
        end
        MULTIPLY: begin
          if (mul_ready) begin
            if (bit_index == '0) begin
              READY    <= 1'b1;
              DATA_OUT <= mul_data;
              state    <= POWER_IDLE;
            end else begin
              // Next bit opens with a square
              bit_index <= bit_index - 1'b1;
              mul_start <= 1'b1;
              state     <= SQUARE;
            end
          end
        end
        default: state <= POWER_IDLE;
      endcase
    end
  end

  // Result starts at 1, so exponent 0 ends as 1 mod p
  always_ff @(posedge CLK) begin
    if (state == POWER_IDLE && START) begin
      modulo_r   <= request.modulo;
      base_r     <= request.base;
      exponent_r <= request.exponent;
      result_r   <= ntm_word_t'(1);
    end else if (mul_ready) begin
      result_r <= mul_data;
    end
  end

  ntm_modular_multiplier multiplier_inst (
    .CLK     (CLK),
    .RST     (RST),
    .START   (mul_start),
    .request (mul_request),
    .READY   (mul_ready),
    .DATA_OUT(mul_data)
  );

  // A field needs p above 1 for the initial 1 to be reduced
  modulo_above_one_a : assert property (@(posedge CLK) disable iff (RST)
    (START && state == POWER_IDLE) |-> request.modulo > ntm_word_t'(1));

endmodule

// ==== hw/ntm_modular_multiplier.sv ====
module ntm_modular_multiplier
  import ntm_arith_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  ntm_product_request_t request,
  output logic                 READY,
  output ntm_word_t            DATA_OUT
);

  // Control
  logic busy;
  ntm_bit_index_t step_count;

  // Working registers
  ntm_word_t modulo_r;
  ntm_word_t multiplicand_r;
  ntm_word_t multiplier_r;
  ntm_word_t accumulator;

  // One extra bit for the carry of double and add
  logic [DATA_SIZE:0] doubled;
  logic [DATA_SIZE:0] summed;
  ntm_word_t next_accumulator;

  //////////////////////////////
  // One step of the scan
  //////////////////////////////

  always_comb begin
    // Double, then fold back below p
    doubled = {accumulator, 1'b0};
    if (doubled >= {1'b0, modulo_r}) begin
      doubled = doubled - {1'b0, modulo_r};
    end
    // Add multiplicand when the current top bit is set
    summed = doubled + (multiplier_r[DATA_SIZE-1] ? {1'b0, multiplicand_r} : '0);
    if (summed >= {1'b0, modulo_r}) begin
      summed = summed - {1'b0, modulo_r};
    end
    next_accumulator = summed[DATA_SIZE-1:0];
  end

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy       <= 1'b0;
      step_count <= '0;
      READY      <= 1'b0;
      DATA_OUT   <= '0;
    end else begin
      READY <= 1'b0;
      if (!busy) begin
        // New product, START while busy falls through
        if (START) begin
          busy       <= 1'b1;
          step_count <= '0;
        end
      end else begin
        step_count <= step_count + 1'b1;
        // Last bit, result leaves with the pulse
        if (step_count == ntm_bit_index_t'(DATA_SIZE - 1)) begin
          busy     <= 1'b0;
          READY    <= 1'b1;
          DATA_OUT <= next_accumulator;
        end
      end
    end
  end

  // Operands and accumulator
  always_ff @(posedge CLK) begin
    if (!busy && START) begin
      modulo_r       <= request.modulo;
      multiplicand_r <= request.multiplicand;
      multiplier_r   <= request.multiplier;
      accumulator    <= '0;
    end else if (busy) begin
      accumulator  <= next_accumulator;
      multiplier_r <= multiplier_r << 1;
    end
  end

  // Caller keeps operands reduced, else one subtraction is not enough
  operands_reduced_a : assert property (@(posedge CLK) disable iff (RST)
    (START && !busy) |-> (request.multiplicand < request.modulo) &&
                         (request.multiplier < request.modulo));

endmodule

// ==== hw/ntm_control_pkg.sv ====
package ntm_control_pkg;

  //////////////////////////////
  // Vector controller
  //////////////////////////////

  typedef enum logic [1:0] {
    STARTER,
    INPUT,
    ENDER
  } ntm_vector_state_t;

  //////////////////////////////
  // Scalar tanh sequencer
  //////////////////////////////

  // Prefixed, the power FSM has its own idle
  typedef enum logic [1:0] {
    SCALAR_IDLE,
    EXPONENTIAL,
    INVERSE,
    PRODUCT
  } ntm_scalar_state_t;

  //////////////////////////////
  // Square and multiply
  //////////////////////////////

  typedef enum logic [1:0] {
    POWER_IDLE,
    SQUARE,
    MULTIPLY
  } ntm_power_state_t;

endpackage

// ==== hw/ntm_arith_pkg.sv ====
package ntm_arith_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Residue and modulus width
  localparam int DATA_SIZE = 16;

  // Element count width
  localparam int INDEX_SIZE = 8;

  // Enough bits to address one bit of a word
  localparam int BIT_INDEX_SIZE = $clog2(DATA_SIZE);

  //////////////////////////////
  // Word types
  //////////////////////////////

  typedef logic [DATA_SIZE-1:0] ntm_word_t;
  typedef logic [INDEX_SIZE-1:0] ntm_index_t;
  typedef logic [BIT_INDEX_SIZE-1:0] ntm_bit_index_t;

  // Base of the exponential, 3 squared, so 9^x = 3^(2x)
  localparam ntm_word_t TANH_BASE_SQUARED = ntm_word_t'(9);

  //////////////////////////////
  // Operand bundles
  //////////////////////////////

  // Multiplier request, all fields mod p
  typedef struct packed {
    ntm_word_t modulo;
    ntm_word_t multiplicand;
    ntm_word_t multiplier;
  } ntm_product_request_t;

  // Exponentiation request
  typedef struct packed {
    ntm_word_t modulo;
    ntm_word_t base;
    ntm_word_t exponent;
  } ntm_power_request_t;

  // One element with its field
  typedef struct packed {
    ntm_word_t modulo;
    ntm_word_t data;
  } ntm_modular_operand_t;

endpackage
